// ==== design/icache_pkg.sv ====
package icache_pkg;

    // ******************************
    // address split
    // ******************************
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = 6;
    localparam int ADDR_W   = 64;
    localparam int WORD_W   = 64;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [2*WORD_W-1:0] line_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;

    // ******************************
    // response codes
    // ******************************
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'd0;
    localparam resp_t RESP_ERR  = 2'd3;

endpackage

// ==== design/icache_if.sv ====
`timescale 1ns/1ps

// lookup stage result, held until advance
interface lookup_if;
    logic              stage_valid;
    logic              hit;
    icache_pkg::addr_t addr;
    icache_pkg::word_t hit_word;
    logic              advance;

    modport source (output stage_valid, hit, addr, hit_word, input advance);
    modport monitor (input stage_valid, hit, addr);
    modport sink (input stage_valid, hit, hit_word, output advance);
endinterface

// one-edge line write into the victim way
interface fill_if;
    logic               fill_wen;
    icache_pkg::index_t fill_index;
    icache_pkg::tag_t   fill_tag;
    icache_pkg::line_t  fill_line;

    modport source (output fill_wen, fill_index, fill_tag, fill_line);
    modport sink (input fill_wen, fill_index, fill_tag, fill_line);
endinterface

// refill result towards the response queue
interface refill_if;
    logic              result_valid;
    icache_pkg::resp_t result_resp;
    icache_pkg::word_t result_word;
    logic              result_ready;

    modport source (
        output result_valid,
        output result_resp,
        output result_word,
        input  result_ready
    );
    modport sink (
        input  result_valid,
        input  result_resp,
        input  result_word,
        output result_ready
    );
endinterface

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at DEPTH
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    no_push_full: assert property (@(posedge clk) disable iff (!rst_n) full |-> !push)
        else $error("sync_fifo: push while full");
    no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop)
        else $error("sync_fifo: pop while empty");

endmodule

// ==== design/cache_array.sv ====
`timescale 1ns/1ps

module cache_array #(
    parameter int WAYS = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush_i,
    input  logic              req_empty,
    input  icache_pkg::addr_t req_addr,
    output logic              req_pop,
    lookup_if.source          lookup,
    fill_if.sink              fill
);

    localparam int SETS    = 1 << icache_pkg::INDEX_W;
    localparam int WAY_W   = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int IDX_LSB = icache_pkg::OFFSET_W;
    localparam int TAG_LSB = icache_pkg::OFFSET_W + icache_pkg::INDEX_W;
    localparam int WORD_W  = $bits(icache_pkg::word_t);

    // ******************************
    // storage
    // ******************************
    icache_pkg::tag_t  tag_mem  [WAYS][SETS];
    icache_pkg::line_t data_mem [WAYS][SETS];
    logic [WAYS-1:0]   valid_q  [SETS];

    icache_pkg::index_t req_index;
    logic [7:0]         lfsr_q;
    logic [WAY_W-1:0]   victim;

    // ******************************
    // lookup stage
    // ******************************
    logic               stage_valid_q;
    icache_pkg::addr_t  stage_addr;
    icache_pkg::tag_t   stage_tag  [WAYS];
    icache_pkg::line_t  stage_line [WAYS];
    logic [WAYS-1:0]    stage_vld;
    logic [WAYS-1:0]    way_hit;
    icache_pkg::tag_t   addr_tag;
    icache_pkg::line_t  hit_line;

    assign req_index = req_addr[TAG_LSB-1:IDX_LSB];
    assign req_pop   = !req_empty && (!stage_valid_q || lookup.advance);
    assign victim    = lfsr_q[WAY_W-1:0];

    // x^8 + x^6 + x^5 + x^4 + 1, never all zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= 8'h01;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (flush_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill.fill_wen) begin
            valid_q[fill.fill_index][victim] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill_wen) begin
            for (int w = 0; w < WAYS; w++) begin
                if (victim == WAY_W'(w)) begin
                    tag_mem[w][fill.fill_index]  <= fill.fill_tag;
                    data_mem[w][fill.fill_index] <= fill.fill_line;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid_q <= 1'b0;
        end else if (req_pop) begin
            stage_valid_q <= 1'b1;
        end else if (lookup.advance) begin
            stage_valid_q <= 1'b0;
        end
    end

    // read all ways on the pop edge
    always_ff @(posedge clk) begin
        if (req_pop) begin
            stage_addr <= req_addr;
            for (int w = 0; w < WAYS; w++) begin
                stage_tag[w]  <= tag_mem[w][req_index];
                stage_line[w] <= data_mem[w][req_index];
                stage_vld[w]  <= valid_q[req_index][w];
            end
        end
    end

    assign addr_tag = stage_addr[$bits(icache_pkg::addr_t)-1:TAG_LSB];

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = stage_vld[w] && (stage_tag[w] == addr_tag);
            if (way_hit[w]) begin
                hit_line = hit_line | stage_line[w];
            end
        end
    end

    assign lookup.stage_valid = stage_valid_q;
    assign lookup.hit         = |way_hit;
    assign lookup.addr        = stage_addr;
    assign lookup.hit_word    = stage_addr[IDX_LSB-1] ? hit_line[2*WORD_W-1:WORD_W]
                                                      : hit_line[WORD_W-1:0];

    // a line is only filled after a miss, so never in two ways
    one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
        stage_valid_q |-> $onehot0(way_hit))
        else $error("cache_array: more than one way hit");

endmodule

// ==== design/refill_engine.sv ====
`timescale 1ns/1ps

module refill_engine #(
    parameter icache_pkg::addr_t PMEM_START = 64'h8000_0000,
    parameter icache_pkg::addr_t PMEM_END   = 64'hFFFF_FFFF
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              mem_arvalid,
    input  logic              mem_arready,
    output icache_pkg::addr_t mem_araddr,
    input  logic              mem_rvalid,
    input  icache_pkg::word_t mem_rdata,
    input  icache_pkg::resp_t mem_rresp,
    input  logic              mem_rlast,
    lookup_if.monitor         lookup,
    fill_if.source            fill,
    refill_if.source          refill
);

    localparam int IDX_LSB = icache_pkg::OFFSET_W;
    localparam int TAG_LSB = icache_pkg::OFFSET_W + icache_pkg::INDEX_W;
    localparam int WORD_W  = $bits(icache_pkg::word_t);

    typedef enum logic [2:0] {
        IDLE      = 3'b000,
        ADDR      = 3'b010,
        BEAT0     = 3'b110,
        ERR_DRAIN = 3'b001,
        BEAT1     = 3'b111,
        WRITE     = 3'b101,
        SEND      = 3'b100
    } refill_state_t;

    refill_state_t     state;
    icache_pkg::resp_t resp_q;
    icache_pkg::line_t line_q;
    logic              beat_err;
    logic              in_window;

    assign beat_err  = (mem_rresp != icache_pkg::RESP_OKAY);
    assign in_window = (lookup.addr >= PMEM_START) && (lookup.addr <= PMEM_END);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            resp_q <= icache_pkg::RESP_OKAY;
        end else begin
            case (state)
                IDLE: begin
                    if (lookup.stage_valid && !lookup.hit) begin
                        state  <= ADDR;
                        resp_q <= icache_pkg::RESP_OKAY;
                    end
                end
                ADDR: begin
                    if (mem_arready) begin
                        state <= BEAT0;
                    end
                end
                BEAT0: begin
                    if (mem_rvalid) begin
                        if (beat_err || mem_rlast) begin
                            // early rlast counts as an error too
                            resp_q <= icache_pkg::RESP_ERR;
                            state  <= mem_rlast ? SEND : ERR_DRAIN;
                        end else begin
                            state <= BEAT1;
                        end
                    end
                end
                ERR_DRAIN: begin
                    if (mem_rvalid && mem_rlast) begin
                        state <= SEND;
                    end
                end
                BEAT1: begin
                    if (mem_rvalid) begin
                        if (beat_err || !mem_rlast) begin
                            resp_q <= icache_pkg::RESP_ERR;
                            state  <= mem_rlast ? SEND : ERR_DRAIN;
                        end else begin
                            state <= in_window ? WRITE : SEND;
                        end
                    end
                end
                WRITE: begin
                    state <= SEND;
                end
                SEND: begin
                    if (refill.result_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // line assembly, low word first
    always_ff @(posedge clk) begin
        if (state == BEAT0 && mem_rvalid) begin
            line_q[WORD_W-1:0] <= mem_rdata;
        end
        if (state == BEAT1 && mem_rvalid) begin
            line_q[2*WORD_W-1:WORD_W] <= mem_rdata;
        end
    end

    assign mem_arvalid = (state == ADDR);
    assign mem_araddr  = {lookup.addr[$bits(icache_pkg::addr_t)-1:IDX_LSB],
                          {icache_pkg::OFFSET_W{1'b0}}};

    assign fill.fill_wen   = (state == WRITE);
    assign fill.fill_index = lookup.addr[TAG_LSB-1:IDX_LSB];
    assign fill.fill_tag   = lookup.addr[$bits(icache_pkg::addr_t)-1:TAG_LSB];
    assign fill.fill_line  = line_q;

    assign refill.result_valid = (state == SEND);
    assign refill.result_resp  = resp_q;
    assign refill.result_word  = lookup.addr[IDX_LSB-1] ? line_q[2*WORD_W-1:WORD_W]
                                                        : line_q[WORD_W-1:0];

    arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else $error("refill_engine: mem_arvalid dropped before mem_arready");

    // the lookup stage must hold the miss address for the whole refill
    miss_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (state != IDLE) |-> $stable(lookup.addr))
        else $error("refill_engine: miss address changed during refill");

endmodule

// ==== design/response_merge.sv ====
`timescale 1ns/1ps

module response_merge (
    input  logic              clk,
    input  logic              rst_n,
    output logic              ifu_rsp_valid,
    input  logic              ifu_rsp_ready,
    output icache_pkg::word_t ifu_rsp_data,
    output icache_pkg::resp_t ifu_rsp_resp,
    lookup_if.sink            lookup,
    refill_if.sink            refill
);

    localparam int WORD_W = $bits(icache_pkg::word_t);
    localparam int RSP_W  = $bits(icache_pkg::resp_t) + WORD_W;

    logic             stage_hit;
    logic             hit_push;
    logic             refill_push;
    logic             push;
    logic             pop;
    logic             rsp_empty;
    logic             rsp_full;
    logic [RSP_W-1:0] rsp_wdata;
    logic [RSP_W-1:0] rsp_rdata;

    // a hit in the stage always wins
    assign stage_hit   = lookup.stage_valid && lookup.hit;
    assign hit_push    = stage_hit && !rsp_full;
    assign refill_push = refill.result_valid && !stage_hit && !rsp_full;
    assign push        = hit_push || refill_push;
    assign pop         = ifu_rsp_valid && ifu_rsp_ready;

    assign rsp_wdata = stage_hit ? {icache_pkg::RESP_OKAY, lookup.hit_word}
                                 : {refill.result_resp, refill.result_word};

    assign lookup.advance      = push;
    assign refill.result_ready = refill_push;

    sync_fifo #(
        .DEPTH (8),
        .WIDTH (RSP_W)
    ) rsp_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (push),
        .pop   (pop),
        .wdata (rsp_wdata),
        .rdata (rsp_rdata),
        .empty (rsp_empty),
        .full  (rsp_full)
    );

    assign ifu_rsp_valid = !rsp_empty;
    assign ifu_rsp_data  = rsp_rdata[WORD_W-1:0];
    assign ifu_rsp_resp  = rsp_rdata[RSP_W-1:WORD_W];

    // refill results only ever belong to a missing stage entry
    refill_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        refill.result_valid |-> lookup.stage_valid && !lookup.hit)
        else $error("response_merge: refill result without a miss in the stage");

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
    parameter int                WAYS       = 2,
    parameter icache_pkg::addr_t PMEM_START = 64'h8000_0000,
    parameter icache_pkg::addr_t PMEM_END   = 64'hFFFF_FFFF
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush_i,
    // fetch side
    input  logic              ifu_req_valid,
    output logic              ifu_req_ready,
    input  icache_pkg::addr_t ifu_req_addr,
    output logic              ifu_rsp_valid,
    input  logic              ifu_rsp_ready,
    output icache_pkg::word_t ifu_rsp_data,
    output icache_pkg::resp_t ifu_rsp_resp,
    // memory side
    output logic              mem_arvalid,
    input  logic              mem_arready,
    output icache_pkg::addr_t mem_araddr,
    input  logic              mem_rvalid,
    input  icache_pkg::word_t mem_rdata,
    input  icache_pkg::resp_t mem_rresp,
    input  logic              mem_rlast
);

    logic              req_push;
    logic              req_pop;
    logic              req_empty;
    logic              req_full;
    icache_pkg::addr_t req_addr;

    lookup_if lookup_bus ();
    fill_if   fill_bus ();
    refill_if refill_bus ();

    assign ifu_req_ready = !req_full;
    assign req_push      = ifu_req_valid && ifu_req_ready;

    sync_fifo #(
        .DEPTH (8),
        .WIDTH ($bits(icache_pkg::addr_t))
    ) req_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (req_push),
        .pop   (req_pop),
        .wdata (ifu_req_addr),
        .rdata (req_addr),
        .empty (req_empty),
        .full  (req_full)
    );

    cache_array #(
        .WAYS (WAYS)
    ) cache_array_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush_i   (flush_i),
        .req_empty (req_empty),
        .req_addr  (req_addr),
        .req_pop   (req_pop),
        .lookup    (lookup_bus.source),
        .fill      (fill_bus.sink)
    );

    refill_engine #(
        .PMEM_START (PMEM_START),
        .PMEM_END   (PMEM_END)
    ) refill_engine_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .mem_rlast   (mem_rlast),
        .lookup      (lookup_bus.monitor),
        .fill        (fill_bus.source),
        .refill      (refill_bus.source)
    );

    response_merge response_merge_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ifu_rsp_valid (ifu_rsp_valid),
        .ifu_rsp_ready (ifu_rsp_ready),
        .ifu_rsp_data  (ifu_rsp_data),
        .ifu_rsp_resp  (ifu_rsp_resp),
        .lookup        (lookup_bus.sink),
        .refill        (refill_bus.sink)
    );

endmodule

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

    localparam int ANY_READS = -1;

    typedef struct {
        string             name;
        icache_pkg::addr_t addr;
        logic              flush;
        icache_pkg::resp_t resp;
        int                reads;
    } test_row_t;

    typedef enum {
        BUS_IDLE,
        BUS_WAIT,
        BUS_BEAT0,
        BUS_BEAT1,
        BUS_LAST
    } bus_phase_t;

    logic              clk;
    logic              rst_n;
    logic              flush_i;
    logic              ifu_req_valid;
    logic              ifu_req_ready;
    icache_pkg::addr_t ifu_req_addr;
    logic              ifu_rsp_valid;
    logic              ifu_rsp_ready;
    icache_pkg::word_t ifu_rsp_data;
    icache_pkg::resp_t ifu_rsp_resp;
    logic              mem_arvalid;
    logic              mem_arready;
    icache_pkg::addr_t mem_araddr;
    logic              mem_rvalid;
    icache_pkg::word_t mem_rdata;
    icache_pkg::resp_t mem_rresp;
    logic              mem_rlast;

    test_row_t         rows[$];
    icache_pkg::word_t rsp_data_q[$];
    icache_pkg::resp_t rsp_resp_q[$];
    logic [31:0]       lfsr_state;
    int                bus_reads;
    int                cycle_limit;
    logic              backpressure_on;
    int                data_errors;
    int                resp_errors;
    int                read_errors;
    int                other_errors;

    icache_top icache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ******************************
    // rule data and random source
    // ******************************
    function automatic icache_pkg::word_t rule_word(input icache_pkg::addr_t addr);
        return {addr[63:3], 3'b000} ^ 64'h5a5a_5a5a_5a5a_5a5a;
    endfunction

    function automatic logic in_error_window(input icache_pkg::addr_t addr);
        return (addr >= 64'h0000_0000_9000_0000) && (addr <= 64'h0000_0000_9000_0fff);
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned random_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // ******************************
    // bus memory model, rsp_ready
    // ******************************
    initial begin : bus_model
        bus_phase_t        phase;
        int                delay;
        icache_pkg::addr_t line_addr;
        lfsr_state    = 32'hdf8a_f264;
        bus_reads     = 0;
        phase         = BUS_IDLE;
        delay         = 0;
        line_addr     = '0;
        mem_arready   <= 1'b0;
        mem_rvalid    <= 1'b0;
        mem_rdata     <= '0;
        mem_rresp     <= icache_pkg::RESP_OKAY;
        mem_rlast     <= 1'b0;
        ifu_rsp_ready <= 1'b1;
        forever begin
            @(posedge clk);
            // ready high one cycle in four under back-pressure
            if (backpressure_on) begin
                ifu_rsp_ready <= (random_bits(2) == 3);
            end else begin
                ifu_rsp_ready <= 1'b1;
            end
            case (phase)
                BUS_IDLE: begin
                    if (rst_n && mem_arvalid) begin
                        delay = int'(random_bits(2));
                        phase = BUS_WAIT;
                    end
                end
                BUS_WAIT: begin
                    delay--;
                end
                BUS_BEAT0: begin
                    mem_arready <= 1'b0;
                    mem_rvalid  <= 1'b1;
                    mem_rdata   <= rule_word(line_addr);
                    mem_rresp   <= in_error_window(line_addr) ? icache_pkg::RESP_ERR
                                                              : icache_pkg::RESP_OKAY;
                    mem_rlast   <= 1'b0;
                    phase = BUS_BEAT1;
                end
                BUS_BEAT1: begin
                    mem_rdata <= rule_word(line_addr + 64'd8);
                    mem_rresp <= icache_pkg::RESP_OKAY;
                    mem_rlast <= 1'b1;
                    phase = BUS_LAST;
                end
                default: begin
                    mem_rvalid <= 1'b0;
                    mem_rlast  <= 1'b0;
                    phase = BUS_IDLE;
                end
            endcase
            if (phase == BUS_WAIT && delay <= 0) begin
                line_addr = mem_araddr;
                assert (line_addr[icache_pkg::OFFSET_W-1:0] == '0) else begin
                    $display("bus read address %h is not line aligned", line_addr);
                    other_errors++;
                end
                mem_arready <= 1'b1;
                bus_reads++;
                phase = BUS_BEAT0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && ifu_rsp_valid && ifu_rsp_ready) begin
            rsp_data_q.push_back(ifu_rsp_data);
            rsp_resp_q.push_back(ifu_rsp_resp);
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    // ******************************
    // stimulus table
    // ******************************
    function automatic void add_row(input string name, input icache_pkg::addr_t addr,
                                    input logic flush, input icache_pkg::resp_t resp,
                                    input int reads);
        test_row_t row;
        row.name  = name;
        row.addr  = addr;
        row.flush = flush;
        row.resp  = resp;
        row.reads = reads;
        rows.push_back(row);
    endfunction

    task automatic load_table;
        add_row("miss_first",      64'h8000_1000, 1'b0, icache_pkg::RESP_OKAY, 1);
        add_row("hit_other_word",  64'h8000_1008, 1'b0, icache_pkg::RESP_OKAY, 0);
        add_row("hit_same_word",   64'h8000_1000, 1'b0, icache_pkg::RESP_OKAY, 0);
        add_row("uncached_first",  64'h0000_2008, 1'b0, icache_pkg::RESP_OKAY, 1);
        add_row("uncached_again",  64'h0000_2008, 1'b0, icache_pkg::RESP_OKAY, 1);
        add_row("bus_error_first", 64'h9000_0040, 1'b0, icache_pkg::RESP_ERR,  1);
        add_row("bus_error_again", 64'h9000_0048, 1'b0, icache_pkg::RESP_ERR,  1);
        add_row("flush_refetch",   64'h8000_1008, 1'b1, icache_pkg::RESP_OKAY, 1);
        add_row("flush_hit",       64'h8000_1000, 1'b0, icache_pkg::RESP_OKAY, 0);
        // set 5 is shared by lines 0x050, 0x450 and 0x850
        add_row("burst_00", 64'h8000_0050, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_01", 64'h8000_0058, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_02", 64'h8000_0450, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_03", 64'h8000_0850, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_04", 64'h8000_0058, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_05", 64'h8000_2000, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_06", 64'h8000_2008, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_07", 64'h8000_0458, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_08", 64'h8000_0850, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_09", 64'h0000_4000, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_10", 64'h8000_3010, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_11", 64'h8000_0050, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_12", 64'h8000_1000, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_13", 64'h8000_3018, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_14", 64'h8000_0858, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_15", 64'h8000_0450, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_16", 64'h0000_4008, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_17", 64'h8000_2000, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_18", 64'h8000_0050, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
        add_row("burst_19", 64'h8000_1008, 1'b0, icache_pkg::RESP_OKAY, ANY_READS);
    endtask

    // ******************************
    // request and check tasks
    // ******************************
    task automatic send_request(input icache_pkg::addr_t addr);
        ifu_req_valid <= 1'b1;
        ifu_req_addr  <= addr;
        @(posedge clk);
        while (!ifu_req_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_responses(input int total);
        while (rsp_data_q.size() < total) begin
            @(posedge clk);
        end
    endtask

    task automatic check_response(input int k);
        assert (rsp_resp_q[k] == rows[k].resp) else begin
            $display("Error %s: expected resp %0d, actual resp %0d",
                     rows[k].name, rows[k].resp, rsp_resp_q[k]);
            resp_errors++;
        end
        // data of an error response is undefined
        if (rows[k].resp == icache_pkg::RESP_OKAY) begin
            assert (rsp_data_q[k] == rule_word(rows[k].addr)) else begin
                $display("Error %s: expected data %h, actual data %h",
                         rows[k].name, rule_word(rows[k].addr), rsp_data_q[k]);
                data_errors++;
            end
        end
    endtask

    task automatic run_single(input int k);
        int reads_before;
        if (rows[k].flush) begin
            flush_i <= 1'b1;
            @(posedge clk);
            flush_i <= 1'b0;
        end
        reads_before = bus_reads;
        send_request(rows[k].addr);
        ifu_req_valid <= 1'b0;
        wait_responses(k + 1);
        check_response(k);
        assert (bus_reads - reads_before == rows[k].reads) else begin
            $display("Error %s: expected bus reads %0d, actual bus reads %0d",
                     rows[k].name, rows[k].reads, bus_reads - reads_before);
            read_errors++;
        end
    endtask

    task automatic run_burst(input int first, input int last);
        backpressure_on <= 1'b1;
        for (int k = first; k < last; k++) begin
            send_request(rows[k].addr);
        end
        ifu_req_valid <= 1'b0;
        wait_responses(last);
        backpressure_on <= 1'b0;
        for (int k = first; k < last; k++) begin
            check_response(k);
        end
    endtask

    initial begin : main
        int k;
        int last;
        data_errors     = 0;
        resp_errors     = 0;
        read_errors     = 0;
        other_errors    = 0;
        backpressure_on = 1'b0;
        rst_n           <= 1'b0;
        flush_i         <= 1'b0;
        ifu_req_valid   <= 1'b0;
        ifu_req_addr    <= '0;
        load_table();
        cycle_limit = rows.size() * 60 + 100;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!ifu_rsp_valid && !mem_arvalid && ifu_req_ready) else begin
            $display("outputs are not idle after reset");
            other_errors++;
        end
        k = 0;
        while (k < rows.size()) begin
            if (rows[k].reads == ANY_READS) begin
                last = k;
                while (last < rows.size() && rows[last].reads == ANY_READS) begin
                    last++;
                end
                run_burst(k, last);
                k = last;
            end else begin
                run_single(k);
                k++;
            end
        end
        // quiet window to catch duplicated responses
        repeat (20) @(posedge clk);
        assert (rsp_data_q.size() == rows.size()) else begin
            $display("Error response_count: expected %0d, actual %0d",
                     rows.size(), rsp_data_q.size());
            other_errors++;
        end
        $display("errors: data %0d, response %0d, bus reads %0d, other %0d",
                 data_errors, resp_errors, read_errors, other_errors);
        if (data_errors + resp_errors + read_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
design/icache_pkg.sv
design/icache_if.sv
design/sync_fifo.sv
design/cache_array.sv
design/refill_engine.sv
design/response_merge.sv
design/icache_top.sv
testbench/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
    --top-module icache_tb -o icache_sim \
    && ./obj_dir/icache_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
